// ==== car_pkg.sv ====
package car_pkg;

    // gear number with 0 as neutral
    typedef logic [1:0] gear_t;

    // engine speed in rpm
    typedef logic [13:0] rpm_t;

    // distance moved on one fast tick
    typedef logic [4:0] dpos_t;

    // accumulated position that wraps at 2^32
    typedef logic [31:0] position_t;

    // gear and rpm latched together on one fast tick
    typedef struct packed {
        gear_t gear;
        rpm_t  rpm;
    } engine_state_t;

    // output of the motion stage
    typedef struct packed {
        dpos_t     d_position;
        position_t position;
    } motion_t;

endpackage

// ==== tuning_pkg.sv ====
package tuning_pkg;

    import car_pkg::*;

    // tick divisors in clk cycles
    localparam int unsigned FAST_DIV = 32'd1_000_000;  // 100 Hz at 100 MHz
    localparam int unsigned SLOW_DIV = 32'd6_500_000;

    // engine speed limits
    localparam rpm_t RPM_IDLE    = 14'd800;
    localparam rpm_t RPM_MAX     = 14'd9000;
    localparam rpm_t RPM_REDLINE = 14'd7500;

    // change per fast tick
    localparam rpm_t RPM_RISE = 14'd100;  // gas held
    localparam rpm_t RPM_FALL = 14'd50;   // gas released

    // ratio per gear with neutral at entry 0
    localparam logic [3:0][1:0] GEAR_RATIO = {
        2'd3,
        2'd2,
        2'd1,
        2'd0
    };

    // rpm times ratio is scaled down by this shift
    // largest step 9000 * 3 >> 10 is 26
    localparam int unsigned DPOS_SHIFT = 10;

endpackage

// ==== tick_gen.sv ====
module tick_gen #(
    parameter int unsigned DIVISOR = 32'd1_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam logic [31:0] RELOAD = 32'(DIVISOR - 1);

    logic [31:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= RELOAD;
            tick  <= 1'b0;
        end else if (count == '0) begin
            count <= RELOAD;
            tick  <= 1'b1;  // one cycle per period
        end else begin
            count <= count - 32'd1;
            tick  <= 1'b0;
        end
    end

endmodule

// ==== driver_controls.sv ====
module driver_controls import car_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  reset_status,
    input  logic  key_tick,
    input  logic  key_pressed,
    input  logic  controller_enable,
    output gear_t gear,
    output logic  gas
);

    logic clear;
    logic shift_en;
    logic gas_en;

    assign clear = rst | reset_status;

    // keys only count while the controller is enabled
    assign shift_en = key_tick & controller_enable;
    assign gas_en   = key_pressed & controller_enable;

    always_ff @(posedge clk) begin
        if (clear) begin
            gear <= '0;
        end else if (shift_en) begin
            gear <= gear + gear_t'(1);  // wraps 3 -> 0
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            gas <= 1'b0;
        end else begin
            gas <= gas_en;
        end
    end

endmodule

// ==== rpm_engine.sv ====
module rpm_engine import car_pkg::*, tuning_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          reset_status,
    input  logic          fast_tick,
    input  gear_t         gear,
    input  logic          gas,
    output engine_state_t engine,
    output logic          redline
);

    logic clear;
    rpm_t rpm_up;
    rpm_t rpm_down;
    rpm_t rpm_next;

    assign clear = rst | reset_status;

    // clamp at RPM_MAX
    always_comb begin
        if (engine.rpm >= RPM_MAX - RPM_RISE) begin
            rpm_up = RPM_MAX;
        end else begin
            rpm_up = engine.rpm + RPM_RISE;
        end
    end

    // clamp at RPM_IDLE
    always_comb begin
        if (engine.rpm <= RPM_IDLE + RPM_FALL) begin
            rpm_down = RPM_IDLE;
        end else begin
            rpm_down = engine.rpm - RPM_FALL;
        end
    end

    assign rpm_next = gas ? rpm_up : rpm_down;

    always_ff @(posedge clk) begin
        if (clear) begin
            engine.gear <= '0;
            engine.rpm  <= RPM_IDLE;
        end else if (fast_tick) begin
            engine.gear <= gear;  // keep gear paired with this rpm
            engine.rpm  <= rpm_next;
        end
    end

    assign redline = (engine.rpm >= RPM_REDLINE);

endmodule

// ==== motion_integrator.sv ====
module motion_integrator import car_pkg::*, tuning_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          reset_status,
    input  logic          fast_tick,
    input  engine_state_t engine,
    output motion_t       motion
);

    localparam int PROD_W = $bits(rpm_t) + 2;

    logic              clear;
    logic [1:0]        ratio;
    logic [PROD_W-1:0] product;
    dpos_t             step;

    assign clear = rst | reset_status;

    // neutral has ratio 0 so step is 0
    assign ratio   = GEAR_RATIO[engine.gear];
    assign product = PROD_W'(engine.rpm) * PROD_W'(ratio);
    assign step    = dpos_t'(product >> DPOS_SHIFT);  // at most 26

    always_ff @(posedge clk) begin
        if (clear) begin
            motion.d_position <= '0;
            motion.position   <= '0;
        end else if (fast_tick) begin
            motion.d_position <= step;
            motion.position   <= motion.position + position_t'(step);  // wraps
        end
    end

endmodule

// ==== gear_and_velocity.sv ====
module gear_and_velocity import car_pkg::*; #(
    parameter int unsigned FAST_TICKS = tuning_pkg::FAST_DIV,
    parameter int unsigned SLOW_TICKS = tuning_pkg::SLOW_DIV
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      reset_status,
    input  logic      key_tick,
    input  logic      key_pressed,
    input  logic      controller_enable,
    output dpos_t     d_position,
    output position_t position,
    output logic      redline,
    output gear_t     current_gear,
    output logic      slow_tick
);

    logic          fast_tick;
    logic          gas;
    engine_state_t engine;
    motion_t       motion;

    tick_gen #(.DIVISOR(FAST_TICKS)) u_fast_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (fast_tick)
    );

    tick_gen #(.DIVISOR(SLOW_TICKS)) u_slow_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (slow_tick)
    );

    driver_controls u_driver_controls (
        .clk               (clk),
        .rst               (rst),
        .reset_status      (reset_status),
        .key_tick          (key_tick),
        .key_pressed       (key_pressed),
        .controller_enable (controller_enable),
        .gear              (current_gear),
        .gas               (gas)
    );

    rpm_engine u_rpm_engine (
        .clk          (clk),
        .rst          (rst),
        .reset_status (reset_status),
        .fast_tick    (fast_tick),
        .gear         (current_gear),
        .gas          (gas),
        .engine       (engine),
        .redline      (redline)
    );

    motion_integrator u_motion_integrator (
        .clk          (clk),
        .rst          (rst),
        .reset_status (reset_status),
        .fast_tick    (fast_tick),
        .engine       (engine),
        .motion       (motion)
    );

    assign d_position = motion.d_position;
    assign position   = motion.position;

endmodule

// ==== tb_gear_and_velocity.sv ====
module tb_gear_and_velocity import car_pkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FAST_TICKS = 8;
    localparam int SLOW_TICKS = 52;

    // model copies of the tuning constants
    localparam int RPM_IDLE    = 800;
    localparam int RPM_MAX     = 9000;
    localparam int RPM_REDLINE = 7500;
    localparam int RPM_RISE    = 100;
    localparam int RPM_FALL    = 50;
    localparam int DPOS_SHIFT  = 10;
    localparam int RATIO [0:3] = '{0, 1, 2, 3};

    typedef struct packed {
        logic       en;          // controller_enable
        logic       gas;         // key_pressed level
        logic [2:0] keys;        // key_tick pulses at row start
        logic       game_reset;  // pulse reset_status first
        logic [7:0] ticks;       // fast ticks to hold
    } row_t;

    localparam int N_ROWS = 11;
    localparam row_t ROWS [N_ROWS] = '{
        '{1'b1, 1'b0, 3'd0, 1'b0, 8'd2},   // reset values in neutral
        '{1'b1, 1'b0, 3'd3, 1'b0, 8'd2},   // step to gear 3 at idle
        '{1'b1, 1'b1, 3'd0, 1'b0, 8'd90},  // rev up past redline to max
        '{1'b1, 1'b0, 3'd0, 1'b0, 8'd40},  // fall back below redline
        '{1'b0, 1'b1, 3'd2, 1'b0, 8'd140}, // keys and gas ignored as rpm falls to idle
        '{1'b1, 1'b1, 3'd1, 1'b0, 8'd10},  // wrap 3 -> 0
        '{1'b1, 1'b1, 3'd1, 1'b0, 8'd10},
        '{1'b1, 1'b0, 3'd1, 1'b0, 8'd10},
        '{1'b1, 1'b1, 3'd0, 1'b1, 8'd6},   // game reset mid run
        '{1'b1, 1'b1, 3'd2, 1'b0, 8'd20},
        '{1'b1, 1'b0, 3'd1, 1'b0, 8'd20}
    };

    logic      clk;
    logic      rst;
    logic      reset_status;
    logic      key_tick;
    logic      key_pressed;
    logic      controller_enable;
    dpos_t     d_position;
    position_t position;
    logic      redline;
    gear_t     current_gear;
    logic      slow_tick;

    // reference model state
    int        m_fcnt;
    int        m_scnt;
    logic      m_fast;
    logic      m_slow;
    logic      m_upd;
    gear_t     m_gear;
    logic      m_gas;
    gear_t     m_eng_gear;
    rpm_t      m_rpm;
    dpos_t     m_dpos;
    position_t m_pos;
    int        m_ticks = 0;
    logic      m_clear;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    gear_and_velocity #(
        .FAST_TICKS (FAST_TICKS),
        .SLOW_TICKS (SLOW_TICKS)
    ) dut (
        .clk               (clk),
        .rst               (rst),
        .reset_status      (reset_status),
        .key_tick          (key_tick),
        .key_pressed       (key_pressed),
        .controller_enable (controller_enable),
        .d_position        (d_position),
        .position          (position),
        .redline           (redline),
        .current_gear      (current_gear),
        .slow_tick         (slow_tick)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic rpm_t next_rpm(rpm_t rpm, logic gas_on);
        int r;
        r = int'(rpm);
        if (gas_on) begin
            r = (r + RPM_RISE > RPM_MAX) ? RPM_MAX : r + RPM_RISE;
        end else begin
            r = (r - RPM_FALL < RPM_IDLE) ? RPM_IDLE : r - RPM_FALL;
        end
        return rpm_t'(r);
    endfunction

    function automatic dpos_t step_for(rpm_t rpm, gear_t g);
        int p;
        p = (int'(rpm) * RATIO[g]) >> DPOS_SHIFT;
        return dpos_t'(p);
    endfunction

    function automatic int timeout_cycles();
        int total;
        total = 0;
        foreach (ROWS[i]) begin
            total += int'(ROWS[i].ticks);
        end
        return total * FAST_TICKS + 100;
    endfunction

    task automatic check_gear(string name, gear_t exp, gear_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_dpos(string name, dpos_t exp, dpos_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_position(string name, position_t exp, position_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    assign m_clear = rst | reset_status;

    // cycle model of the drivetrain rules
    always @(posedge clk) begin
        if (rst) begin
            m_fcnt <= 0;
            m_scnt <= 0;
            m_fast <= 1'b0;
            m_slow <= 1'b0;
        end else begin
            m_fast <= (m_fcnt == FAST_TICKS - 1);
            m_fcnt <= (m_fcnt == FAST_TICKS - 1) ? 0 : m_fcnt + 1;
            m_slow <= (m_scnt == SLOW_TICKS - 1);
            m_scnt <= (m_scnt == SLOW_TICKS - 1) ? 0 : m_scnt + 1;
        end
        if (!rst && m_fast) begin
            m_ticks <= m_ticks + 1;  // tick phase survives reset_status
        end
        if (m_clear) begin
            m_gear     <= '0;
            m_gas      <= 1'b0;
            m_eng_gear <= '0;
            m_rpm      <= rpm_t'(RPM_IDLE);
            m_dpos     <= '0;
            m_pos      <= '0;
        end else begin
            if (key_tick && controller_enable) begin
                m_gear <= m_gear + 2'd1;
            end
            m_gas <= key_pressed & controller_enable;
            if (m_fast) begin
                m_eng_gear <= m_gear;
                m_rpm      <= next_rpm(m_rpm, m_gas);
                m_dpos     <= step_for(m_rpm, m_eng_gear);
                m_pos      <= m_pos + position_t'(step_for(m_rpm, m_eng_gear));
            end
        end
        m_upd <= m_clear | m_fast;
    end

    // outputs are compared half a cycle after the edge
    always @(negedge clk) begin
        if (!rst) begin
            check_flag("slow_tick", m_slow, slow_tick);
            check_gear("current_gear", m_gear, current_gear);
            if (m_upd) begin
                check_dpos("d_position", m_dpos, d_position);
                check_position("position", m_pos, position);
                check_flag("redline", int'(m_rpm) >= RPM_REDLINE, redline);
            end
        end
    end

    initial begin
        int limit;
        limit = timeout_cycles();
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("run timed out after %0d cycles", cycles);
        $display("rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        row_t row;
        int   start;
        int   errors_before;
        rst               = 1'b1;
        reset_status      = 1'b0;
        key_tick          = 1'b0;
        key_pressed       = 1'b0;
        controller_enable = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            row           = ROWS[i];
            errors_before = errors;
            start         = m_ticks;
            @(posedge clk);
            controller_enable <= row.en;
            key_pressed       <= row.gas;
            reset_status      <= row.game_reset;
            @(posedge clk);
            reset_status <= 1'b0;
            for (int k = 0; k < int'(row.keys); k++) begin
                key_tick <= 1'b1;
                @(posedge clk);
                key_tick <= 1'b0;
                @(posedge clk);
            end
            while (m_ticks < start + int'(row.ticks)) begin
                @(posedge clk);
            end
            $display("row %0d done: gear %0d, position %0h, %0d new errors",
                     i, current_gear, position, errors - errors_before);
        end
        $display("rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
car_pkg.sv
tuning_pkg.sv
tick_gen.sv
driver_controls.sv
rpm_engine.sv
motion_integrator.sv
gear_and_velocity.sv
tb_gear_and_velocity.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gear_and_velocity
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
